/* fix_pkg.sv */
/*
 * fix receiver shared definitions
 * byte codes, sizes and the packed records passed between the
 * checksum channels, the Wishbone arbiter and the verdict log
 */
package fix_pkg;

	// receive channels and verdict log geometry
	localparam int NUM_CH    = 2;
	localparam int LOG_DEPTH = 16;
	localparam int LOG_AW    = 4;

	// byte codes seen on the wire
	localparam logic [7:0] SOH        = 8'h01;
	localparam logic [7:0] ASCII_ZERO = 8'h30;
	localparam logic [7:0] ASCII_NINE = 8'h39;
	localparam logic [7:0] ASCII_EQ   = 8'h3d;

	// digits in the "10=ddd" trailer
	localparam int CHK_DIGITS = 3;

	// one byte of the input stream
	typedef struct packed {
		logic [7:0] data;
		logic       valid;
	} rx_byte_t;

	// result of one message
	typedef struct packed {
		logic [7:0] seq;
		logic [7:0] calc;
		logic [7:0] rcvd;
		logic       match;
		logic       malformed;
	} verdict_t;

	// wishbone classic master request, writes only
	typedef struct packed {
		logic     cyc;
		logic     stb;
		logic     we;
		verdict_t data;
	} wb_req_t;

	// record as stored in the log, tagged with the source channel
	typedef struct packed {
		logic     ch;
		verdict_t verdict;
	} log_entry_t;

endpackage

/* ascii_decimal_parser.sv */
/*
 * ascii_decimal_parser
 * turns the checksum digits of a trailer into a binary value,
 * modulo 256, and flags non-digit bytes or too many digits
 */
`timescale 1ns/1ps

module ascii_decimal_parser (
	input  logic       clk,
	input  logic       rst,
	input  logic       start_i,
	input  logic [7:0] byte_i,
	input  logic       take_i,
	output logic [7:0] value_o,
	output logic       malformed_o
);

	logic [7:0] acc_q;
	logic [$clog2(fix_pkg::CHK_DIGITS+1)-1:0] cnt_q;
	logic bad_q;
	logic is_digit;
	logic [7:0] digit;

	assign is_digit = (byte_i >= fix_pkg::ASCII_ZERO) && (byte_i <= fix_pkg::ASCII_NINE);
	assign digit = byte_i - fix_pkg::ASCII_ZERO;

	always_ff @(posedge clk) begin
		if (rst) begin
			acc_q <= '0;
			cnt_q <= '0;
			bad_q <= 1'b0;
		end else if (start_i) begin
			acc_q <= '0;
			cnt_q <= '0;
			bad_q <= 1'b0;
		end else if (take_i) begin
			if (!is_digit) begin
				bad_q <= 1'b1;
			end else if (int'(cnt_q) >= fix_pkg::CHK_DIGITS) begin
				// a fourth digit spoils the trailer
				bad_q <= 1'b1;
			end else begin
				// wraps naturally at 8 bits
				acc_q <= acc_q * 8'd10 + digit;
				cnt_q <= cnt_q + 1'b1;
			end
		end
	end

	assign value_o = acc_q;
	assign malformed_o = bad_q;

endmodule

/* fix_checksum.sv */
/*
 * fix_checksum
 * one receive channel. follows a frame from the opening "8" to the
 * closing SOH of the "10=ddd" trailer, keeps the byte sum modulo 256,
 * compares it with the decoded trailer and posts the verdict as a
 * single Wishbone classic write
 */
`timescale 1ns/1ps

module fix_checksum (
	input  logic              clk,
	input  logic              rst,
	input  fix_pkg::rx_byte_t rx_i,
	output logic              ready_o,
	output fix_pkg::wb_req_t  wb_o,
	input  logic              ack_i
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_BODY,
		S_TAG1,
		S_TAG0,
		S_TAGEQ,
		S_TRAIL,
		S_WRITE
	} state_t;

	state_t state_q;
	state_t tag_adv;
	logic [7:0] tag_exp;
	logic accept;
	logic is_soh;
	logic in_body;
	logic verdict_done;
	logic [7:0] sum_q;
	logic [7:0] sum_nxt;
	logic [7:0] snap_q;
	logic [7:0] seq_q;
	logic parse_start;
	logic parse_take;
	logic [7:0] rcvd;
	logic bad_trailer;
	logic cyc_q;
	fix_pkg::verdict_t verdict_q;

	// no new bytes while a verdict write is outstanding
	assign ready_o = ~cyc_q;
	assign accept = rx_i.valid & ready_o;
	assign is_soh = rx_i.data == fix_pkg::SOH;
	assign sum_nxt = sum_q + rx_i.data;
	assign in_body = state_q inside {S_BODY, S_TAG1, S_TAG0, S_TAGEQ};
	assign verdict_done = accept && (state_q == S_TRAIL) && is_soh;

	// parser is cleared on the "=" of "10=" and then sees digits only
	assign parse_start = accept && (state_q == S_TAGEQ) && (rx_i.data == fix_pkg::ASCII_EQ);
	assign parse_take = accept && (state_q == S_TRAIL) && !is_soh;

	// expected byte and next state while matching "10="
	always_comb begin
		tag_exp = fix_pkg::ASCII_EQ;
		tag_adv = S_TRAIL;
		case (state_q)
			S_TAG1: begin
				tag_exp = fix_pkg::ASCII_ZERO + 8'd1;
				tag_adv = S_TAG0;
			end
			S_TAG0: begin
				tag_exp = fix_pkg::ASCII_ZERO;
				tag_adv = S_TAGEQ;
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= S_IDLE;
		end else begin
			case (state_q)
				S_IDLE: begin
					// anything but "8" between frames is dropped
					if (accept && rx_i.data == fix_pkg::ASCII_ZERO + 8'd8) begin
						state_q <= S_BODY;
					end
				end
				S_BODY: begin
					if (accept && is_soh) begin
						state_q <= S_TAG1;
					end
				end
				S_TAG1, S_TAG0, S_TAGEQ: begin
					if (accept) begin
						if (is_soh) begin
							state_q <= S_TAG1;
						end else if (rx_i.data == tag_exp) begin
							state_q <= tag_adv;
						end else begin
							state_q <= S_BODY;
						end
					end
				end
				S_TRAIL: begin
					if (verdict_done) begin
						state_q <= S_WRITE;
					end
				end
				S_WRITE: begin
					if (ack_i) begin
						state_q <= S_IDLE;
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// running sum, snapshot taken at each SOH inside the frame
	always_ff @(posedge clk) begin
		if (accept) begin
			if (state_q == S_IDLE) begin
				sum_q <= rx_i.data;
			end else begin
				sum_q <= sum_nxt;
			end
			if (in_body && is_soh) begin
				snap_q <= sum_nxt;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cyc_q <= 1'b0;
			seq_q <= '0;
		end else if (verdict_done) begin
			cyc_q <= 1'b1;
			seq_q <= seq_q + 8'd1;
		end else if (ack_i) begin
			cyc_q <= 1'b0;
		end
	end

	// verdict payload, held until ack
	always_ff @(posedge clk) begin
		if (verdict_done) begin
			verdict_q.seq <= seq_q;
			verdict_q.calc <= snap_q;
			verdict_q.rcvd <= rcvd;
			verdict_q.match <= (snap_q == rcvd) && !bad_trailer;
			verdict_q.malformed <= bad_trailer;
		end
	end

	assign wb_o = '{cyc: cyc_q, stb: cyc_q, we: 1'b1, data: verdict_q};

	ascii_decimal_parser i_parser (
		.clk         (clk),
		.rst         (rst),
		.start_i     (parse_start),
		.byte_i      (rx_i.data),
		.take_i      (parse_take),
		.value_o     (rcvd),
		.malformed_o (bad_trailer)
	);

endmodule

/* wb_arbiter.sv */
/*
 * wb_arbiter
 * round-robin Wishbone classic arbiter for the two checksum
 * channels. the grant is held for a whole bus cycle and the
 * forwarded record carries the granted channel number
 */
`timescale 1ns/1ps

module wb_arbiter (
	input  logic                        clk,
	input  logic                        rst,
	input  fix_pkg::wb_req_t            req_i [fix_pkg::NUM_CH],
	output logic [fix_pkg::NUM_CH-1:0]  ack_o,
	output logic                        stb_o,
	output fix_pkg::log_entry_t         entry_o,
	input  logic                        ack_i
);

	logic [$clog2(fix_pkg::NUM_CH)-1:0] grant_q;
	logic [$clog2(fix_pkg::NUM_CH)-1:0] last_q;
	logic [$clog2(fix_pkg::NUM_CH)-1:0] pick;
	logic busy_q;
	logic locked;
	logic any_req;

	always_comb begin
		any_req = 1'b0;
		for (int i = 0; i < fix_pkg::NUM_CH; i++) begin
			any_req = any_req | req_i[i].cyc;
		end
	end

	// the master not served last has priority
	always_comb begin
		if (req_i[~last_q].cyc) begin
			pick = ~last_q;
		end else begin
			pick = last_q;
		end
	end

	// grant stays put while the owner keeps cyc up
	assign locked = busy_q && req_i[grant_q].cyc;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q <= 1'b0;
			grant_q <= '0;
			// channel 0 wins a tie right after reset
			last_q <= '1;
		end else if (!locked) begin
			if (any_req) begin
				busy_q <= 1'b1;
				grant_q <= pick;
				last_q <= pick;
			end else begin
				busy_q <= 1'b0;
			end
		end
	end

	assign stb_o = busy_q && req_i[grant_q].cyc && req_i[grant_q].stb && req_i[grant_q].we;

	always_comb begin
		ack_o = '0;
		if (busy_q) begin
			ack_o[grant_q] = ack_i;
		end
	end

	assign entry_o = '{ch: grant_q, verdict: req_i[grant_q].data};

endmodule

/* verdict_log.sv */
/*
 * verdict_log
 * Wishbone slave that appends each written record to the next
 * free slot. full log acks but drops the record and raises a
 * sticky overflow flag. slots are read back over a registered port
 */
`timescale 1ns/1ps

module verdict_log (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      stb_i,
	input  fix_pkg::log_entry_t       entry_i,
	output logic                      ack_o,
	input  logic [fix_pkg::LOG_AW-1:0] rd_addr_i,
	output fix_pkg::log_entry_t       rd_data_o,
	output logic [fix_pkg::LOG_AW:0]  count_o,
	output logic                      overflow_o
);

	fix_pkg::log_entry_t mem [fix_pkg::LOG_DEPTH];
	logic [fix_pkg::LOG_AW-1:0] wr_ptr_q;
	logic [fix_pkg::LOG_AW:0] count_q;
	logic ack_q;
	logic ovf_q;
	logic wr_en;
	logic full;

	// one ack per strobe, the cycle after it is seen
	assign wr_en = stb_i && !ack_q;
	assign full = int'(count_q) == fix_pkg::LOG_DEPTH;

	always_ff @(posedge clk) begin
		if (rst) begin
			ack_q <= 1'b0;
			wr_ptr_q <= '0;
			count_q <= '0;
			ovf_q <= 1'b0;
		end else begin
			ack_q <= wr_en;
			if (wr_en) begin
				if (full) begin
					ovf_q <= 1'b1;
				end else begin
					wr_ptr_q <= wr_ptr_q + 1'b1;
					count_q <= count_q + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en && !full) begin
			mem[wr_ptr_q] <= entry_i;
		end
		rd_data_o <= mem[rd_addr_i];
	end

	assign ack_o = ack_q;
	assign count_o = count_q;
	assign overflow_o = ovf_q;

endmodule

/* fix_rx_top.sv */
/*
 * fix_rx_top
 * two-channel FIX checksum receiver. each channel posts its
 * verdicts through the round-robin arbiter into the verdict log
 */
`timescale 1ns/1ps

module fix_rx_top (
	input  logic                       clk,
	input  logic                       rst,
	input  fix_pkg::rx_byte_t          rx0_i,
	input  fix_pkg::rx_byte_t          rx1_i,
	output logic                       ready0_o,
	output logic                       ready1_o,
	input  logic [fix_pkg::LOG_AW-1:0] rd_addr_i,
	output fix_pkg::log_entry_t        rd_data_o,
	output logic [fix_pkg::LOG_AW:0]   count_o,
	output logic                       overflow_o
);

	fix_pkg::wb_req_t req [fix_pkg::NUM_CH];
	logic [fix_pkg::NUM_CH-1:0] ack;
	logic log_stb;
	logic log_ack;
	fix_pkg::log_entry_t log_entry;

	fix_checksum i_ch0 (
		.clk     (clk),
		.rst     (rst),
		.rx_i    (rx0_i),
		.ready_o (ready0_o),
		.wb_o    (req[0]),
		.ack_i   (ack[0])
	);

	fix_checksum i_ch1 (
		.clk     (clk),
		.rst     (rst),
		.rx_i    (rx1_i),
		.ready_o (ready1_o),
		.wb_o    (req[1]),
		.ack_i   (ack[1])
	);

	wb_arbiter i_arb (
		.clk     (clk),
		.rst     (rst),
		.req_i   (req),
		.ack_o   (ack),
		.stb_o   (log_stb),
		.entry_o (log_entry),
		.ack_i   (log_ack)
	);

	verdict_log i_log (
		.clk        (clk),
		.rst        (rst),
		.stb_i      (log_stb),
		.entry_i    (log_entry),
		.ack_o      (log_ack),
		.rd_addr_i  (rd_addr_i),
		.rd_data_o  (rd_data_o),
		.count_o    (count_o),
		.overflow_o (overflow_o)
	);

endmodule

/* fix_rx_props.sv */
/*
 * fix_rx_props
 * concurrent checks on the receiver top level. input back-pressure,
 * arbiter acks, log fill count and the sticky overflow flag
 */
`timescale 1ns/1ps

module fix_rx_props (
	input logic                       clk,
	input logic                       rst,
	input logic                       ready0_i,
	input logic                       ready1_i,
	input fix_pkg::wb_req_t           req_i [fix_pkg::NUM_CH],
	input logic [fix_pkg::NUM_CH-1:0] ack_i,
	input logic [fix_pkg::LOG_AW:0]   count_i,
	input logic                       overflow_i
);

	int fail_cnt = 0;

	// an open write stays up with steady data, and no byte is taken, until ack
	ready0_held: assert property (@(posedge clk) disable iff (rst)
		req_i[0].cyc && !ack_i[0] |=> req_i[0].cyc && $stable(req_i[0].data) && !ready0_i)
		else begin
			$error("channel 0 write not held until ack");
			fail_cnt++;
		end

	ready1_held: assert property (@(posedge clk) disable iff (rst)
		req_i[1].cyc && !ack_i[1] |=> req_i[1].cyc && $stable(req_i[1].data) && !ready1_i)
		else begin
			$error("channel 1 write not held until ack");
			fail_cnt++;
		end

	// acks go to one requesting master at a time
	single_grant: assert property (@(posedge clk) disable iff (rst)
		$onehot0(ack_i) && ((ack_i & ~{req_i[1].cyc, req_i[0].cyc}) == '0))
		else begin
			$error("ack sent to both masters or to an idle master");
			fail_cnt++;
		end

	count_rising: assert property (@(posedge clk) disable iff (rst)
		(count_i >= $past(count_i)) && (int'(count_i) <= fix_pkg::LOG_DEPTH))
		else begin
			$error("log count fell or passed the depth");
			fail_cnt++;
		end

	overflow_sticky: assert property (@(posedge clk) disable iff (rst)
		overflow_i |=> overflow_i)
		else begin
			$error("overflow flag cleared without reset");
			fail_cnt++;
		end

endmodule

bind fix_rx_top fix_rx_props i_props (
	.clk        (clk),
	.rst        (rst),
	.ready0_i   (ready0_o),
	.ready1_i   (ready1_o),
	.req_i      (req),
	.ack_i      (ack),
	.count_i    (count_o),
	.overflow_i (overflow_o)
);

/* tb_fix_rx.sv */
/*
 * tb_fix_rx
 * testbench for the two-channel FIX checksum receiver. builds random
 * messages, drives both channels and reads the verdict log back
 */
`timescale 1ns/1ps

module tb_fix_rx;

	localparam int TIMEOUT = 2000;

	logic clk;
	logic rst;
	fix_pkg::rx_byte_t rx [fix_pkg::NUM_CH];
	logic [fix_pkg::NUM_CH-1:0] ready;
	logic [fix_pkg::LOG_AW-1:0] rd_addr;
	fix_pkg::log_entry_t rd_data;
	logic [fix_pkg::LOG_AW:0] count;
	logic overflow;

	// expected log contents in write order
	fix_pkg::log_entry_t exp_log [$];
	bit exp_rcvd_known [$];
	logic [7:0] seq_cnt [fix_pkg::NUM_CH];
	int last_ch;
	int gap_max;
	int errors;
	int tests;
	int failed;
	int test_err;

	fix_rx_top i_fix_rx_top (
		.clk        (clk),
		.rst        (rst),
		.rx0_i      (rx[0]),
		.rx1_i      (rx[1]),
		.ready0_o   (ready[0]),
		.ready1_o   (ready[1]),
		.rd_addr_i  (rd_addr),
		.rd_data_o  (rd_data),
		.count_o    (count),
		.overflow_o (overflow)
	);

	always #20 clk = ~clk;

	task automatic abort_run(input string what);
		$display("timeout: %s", what);
		$display("Simulation failed");
		$finish;
	endtask

	function automatic logic [7:0] digit_char(input int d);
		return fix_pkg::ASCII_ZERO + 8'(d % 10);
	endfunction

	// mode 0 correct, 1 wrong digits, 2 non-digit, 3 four digits
	task automatic build_msg(input int ch, input int nfields, input int mode,
			output logic [7:0] msg [$], output fix_pkg::verdict_t v);
		string head;
		logic [7:0] sum;
		int rv;
		head = "8=FIX.4.4";
		msg = {};
		for (int i = 0; i < head.len(); i++) begin
			msg.push_back(head[i]);
		end
		msg.push_back(fix_pkg::SOH);
		for (int f = 0; f < nfields; f++) begin
			repeat (3) msg.push_back(8'h41 + 8'($urandom % 26));
			msg.push_back(fix_pkg::SOH);
		end
		// modulo-256 sum up to and including the SOH before "10="
		sum = '0;
		foreach (msg[i]) begin
			sum += msg[i];
		end
		rv = sum;
		if (mode == 1) begin
			rv = 300 + int'($urandom % 600);
			if (rv % 256 == sum) begin
				rv++;
			end
		end
		msg.push_back("1");
		msg.push_back("0");
		msg.push_back("=");
		if (mode == 3) begin
			msg.push_back("0");
		end
		msg.push_back(digit_char(rv / 100));
		msg.push_back(mode == 2 ? "X" : digit_char(rv / 10));
		msg.push_back(digit_char(rv));
		msg.push_back(fix_pkg::SOH);
		v.seq = seq_cnt[ch];
		seq_cnt[ch]++;
		v.calc = sum;
		v.rcvd = rv[7:0];
		v.match = (mode == 0);
		v.malformed = (mode >= 2);
	endtask

	task automatic send_byte(input int ch, input logic [7:0] b);
		int idle;
		int t;
		idle = (gap_max > 0) ? int'($urandom % (gap_max + 1)) : 0;
		for (int i = 0; i < idle; i++) begin
			rx[ch] <= '{data: 8'($urandom), valid: 1'b0};
			@(posedge clk);
		end
		rx[ch] <= '{data: b, valid: 1'b1};
		t = 0;
		// held until the channel samples it with ready high
		do begin
			@(posedge clk);
			t++;
			if (t > TIMEOUT) begin
				abort_run("channel input never became ready");
			end
		end while (!ready[ch]);
	endtask

	task automatic send_msg(input int ch, input logic [7:0] msg [$]);
		foreach (msg[i]) begin
			send_byte(ch, msg[i]);
		end
		rx[ch] <= '{data: 8'h00, valid: 1'b0};
	endtask

	task automatic push_expected(input int ch, input fix_pkg::verdict_t v, input bit known);
		exp_log.push_back('{ch: ch[0], verdict: v});
		exp_rcvd_known.push_back(known);
		last_ch = ch;
	endtask

	task automatic wait_count(input int target);
		int t;
		t = 0;
		while (int'(count) != target) begin
			@(posedge clk);
			t++;
			if (t > TIMEOUT) begin
				abort_run("verdict log count did not reach the expected value");
			end
		end
	endtask

	task automatic wait_ready();
		int t;
		t = 0;
		while (ready != '1) begin
			@(posedge clk);
			t++;
			if (t > TIMEOUT) begin
				abort_run("channels stayed busy");
			end
		end
	endtask

	task automatic check_field(input string name, input logic [31:0] exp,
			input logic [31:0] got);
		assert (exp === got) else begin
			$display("ERROR %0t %s expected %0h got %0h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic check_slot(input int idx);
		fix_pkg::log_entry_t e;
		rd_addr <= idx[fix_pkg::LOG_AW-1:0];
		// registered read port, data valid one cycle after the address
		@(posedge clk);
		@(posedge clk);
		e = exp_log[idx];
		check_field($sformatf("rd_data_o.ch[%0d]", idx), e.ch, rd_data.ch);
		check_field($sformatf("rd_data_o.seq[%0d]", idx), e.verdict.seq, rd_data.verdict.seq);
		check_field($sformatf("rd_data_o.calc[%0d]", idx), e.verdict.calc, rd_data.verdict.calc);
		if (exp_rcvd_known[idx]) begin
			check_field($sformatf("rd_data_o.rcvd[%0d]", idx), e.verdict.rcvd,
				rd_data.verdict.rcvd);
		end
		check_field($sformatf("rd_data_o.match[%0d]", idx), e.verdict.match,
			rd_data.verdict.match);
		check_field($sformatf("rd_data_o.malformed[%0d]", idx), e.verdict.malformed,
			rd_data.verdict.malformed);
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (errors == test_err) begin
			$display("test %0d %s: ok", tests, name);
		end else begin
			failed++;
			$display("test %0d %s: FAILED, %0d errors", tests, name, errors - test_err);
		end
		test_err = errors;
	endtask

	initial begin
		fix_pkg::verdict_t v0;
		fix_pkg::verdict_t v1;
		logic [7:0] m0 [$];
		logic [7:0] m1 [$];
		int base;
		clk = 1'b0;
		rst = 1'b1;
		rx[0] = '0;
		rx[1] = '0;
		rd_addr = '0;
		seq_cnt[0] = '0;
		seq_cnt[1] = '0;
		last_ch = 1;
		gap_max = 0;
		errors = 0;
		tests = 0;
		failed = 0;
		test_err = 0;
		void'($urandom(32'h9a4c5bfd));
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);

		// junk letters ahead of the frame are skipped
		repeat (4) send_byte(0, 8'h41 + 8'($urandom % 26));
		build_msg(0, 4, 0, m0, v0);
		send_msg(0, m0);
		push_expected(0, v0, 1'b1);
		wait_count(1);
		check_slot(0);
		finish_test("correct message");

		build_msg(0, 3, 1, m0, v0);
		send_msg(0, m0);
		push_expected(0, v0, 1'b1);
		wait_count(2);
		check_slot(1);
		finish_test("wrong trailer");

		build_msg(0, 2, 2, m0, v0);
		send_msg(0, m0);
		push_expected(0, v0, 1'b0);
		build_msg(0, 5, 3, m0, v0);
		send_msg(0, m0);
		push_expected(0, v0, 1'b0);
		wait_count(4);
		check_slot(2);
		check_slot(3);
		finish_test("malformed trailer");

		// equal lengths so both final SOH bytes land on one edge
		wait_ready();
		base = count;
		build_msg(0, 5, 0, m0, v0);
		build_msg(1, 5, 0, m1, v1);
		if (last_ch == 0) begin
			push_expected(1, v1, 1'b1);
			push_expected(0, v0, 1'b1);
		end else begin
			push_expected(0, v0, 1'b1);
			push_expected(1, v1, 1'b1);
		end
		fork
			send_msg(0, m0);
			send_msg(1, m1);
		join
		wait_count(base + 2);
		check_slot(base);
		check_slot(base + 1);
		finish_test("both channels");

		gap_max = 3;
		for (int i = 0; i < 3; i++) begin
			build_msg(1, 2 + i, 0, m1, v1);
			send_msg(1, m1);
			push_expected(1, v1, 1'b1);
		end
		gap_max = 0;
		wait_count(9);
		for (int i = 6; i < 9; i++) begin
			check_slot(i);
		end
		finish_test("back-pressure");

		gap_max = 1;
		for (int i = 0; i < 9; i++) begin
			build_msg(0, 3, 0, m0, v0);
			send_msg(0, m0);
			push_expected(0, v0, 1'b1);
		end
		gap_max = 0;
		// last write opens its cycle on this edge
		@(posedge clk);
		wait_ready();
		check_field("count_o", fix_pkg::LOG_DEPTH, count);
		check_field("overflow_o", 1, overflow);
		for (int i = 0; i < fix_pkg::LOG_DEPTH; i++) begin
			check_slot(i);
		end
		finish_test("overflow");

		errors += i_fix_rx_top.i_props.fail_cnt;
		$display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* verilog.f */
fix_pkg.sv
ascii_decimal_parser.sv
fix_checksum.sv
wb_arbiter.sv
verdict_log.sv
fix_rx_top.sv
fix_rx_props.sv
tb_fix_rx.sv
